//--- mipsDefines.svh
// ====================
// opcode, function code and width macros shared by the core and testbench
// include once per file that needs them
// ====================
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath and address width
`define MIPS_XLEN 32
// architectural registers
`define MIPS_NREG 32
// data memory word address width, 128 words
`define MIPS_DADDR_W 7

// ==================== opcodes
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// ==================== function codes
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010
`define FN_JR  6'b001000

`endif

//--- mipsPkg.sv
// ====================
// ALU and control types used between the decode, ALU and top of the core
// ====================
`default_nettype none

package mipsPkg;

  // which ALU function an instruction class asks for
  typedef enum logic [1:0] {
    CLS_MEM    = 2'd0,
    CLS_BRANCH = 2'd1,
    CLS_RTYPE  = 2'd2
  } aluClassT;

  // ALU operation codes
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0000,
    ALU_OR   = 4'b0001,
    ALU_ADD  = 4'b0010,
    ALU_SUB  = 4'b0110,
    ALU_SLT  = 4'b0111,
    ALU_NONE = 4'b1111
  } aluOpT;

  // decoded control for one instruction
  typedef struct packed {
    logic     regDst;
    logic     aluSrc;
    logic     memToReg;
    logic     regWrite;
    logic     memWrite;
    logic     jump;
    logic     branch;
    logic     link;
    logic     jumpReg;
    aluClassT aluClass;
  } ctrlT;

endpackage

`default_nettype wire

//--- regFileIf.sv
// ====================
// register file bundle, two read ports and one write port
// ====================
`include "mipsDefines.svh"
`timescale 1ns/1ps
`default_nettype none

interface regFileIf;
  // read addresses and data
  logic [$clog2(`MIPS_NREG)-1:0] raddr1;
  logic [$clog2(`MIPS_NREG)-1:0] raddr2;
  logic [`MIPS_XLEN-1:0]         rdata1;
  logic [`MIPS_XLEN-1:0]         rdata2;
  // write port
  logic [$clog2(`MIPS_NREG)-1:0] waddr;
  logic [`MIPS_XLEN-1:0]         wdata;
  logic                          we;

  modport core (output raddr1, raddr2, waddr, wdata, we,
                input rdata1, rdata2);

  modport regFile (input raddr1, raddr2, waddr, wdata, we,
                   output rdata1, rdata2);
endinterface

`default_nettype wire

//--- mainDecode.sv
// ====================
// main control decode, opcode and funct into the control struct
// ====================
`include "mipsDefines.svh"
`timescale 1ns/1ps
`default_nettype none

module mainDecode (
  input  wire logic [5:0]   opcode,
  input  wire logic [5:0]   funct,
  output mipsPkg::ctrlT     ctrl
);
  import mipsPkg::*;

  always_comb begin
    // everything off unless an opcode below turns it on
    ctrl          = '0;
    ctrl.aluClass = CLS_MEM;
    case (opcode)
      `OP_RTYPE: begin
        // rd destination, register operand
        ctrl.regDst   = 1'b1;
        ctrl.aluClass = CLS_RTYPE;
        if (funct == `FN_JR) begin
          // jr writes nothing back
          ctrl.jumpReg = 1'b1;
        end else begin
          // all-zero word lands here and writes r0
          ctrl.regWrite = 1'b1;
        end
      end
      `OP_LW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OP_SW: begin
        // address is base plus offset
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      `OP_BEQ: begin
        // subtract, zero flag decides
        ctrl.branch   = 1'b1;
        ctrl.aluClass = CLS_BRANCH;
      end
      `OP_J: begin
        ctrl.jump = 1'b1;
      end
      `OP_JAL: begin
        // link to r31 with pc+4
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unsupported opcode acts as a no-op
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- aluUnit.sv
// ====================
// ALU control decode and 32-bit ALU with zero flag
// ====================
`include "mipsDefines.svh"
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  wire mipsPkg::aluClassT       aluClass,
  input  wire logic [5:0]              funct,
  input  wire logic [`MIPS_XLEN-1:0]   a,
  input  wire logic [`MIPS_XLEN-1:0]   b,
  output logic [`MIPS_XLEN-1:0]        result,
  output logic                         zero
);
  import mipsPkg::*;

  aluOpT aluOp;

  // ==================== operation select
  always_comb begin
    case (aluClass)
      CLS_MEM:    aluOp = ALU_ADD;
      CLS_BRANCH: aluOp = ALU_SUB;
      CLS_RTYPE: begin
        // R-type follows the function code
        case (funct)
          `FN_ADD: aluOp = ALU_ADD;
          `FN_SUB: aluOp = ALU_SUB;
          `FN_AND: aluOp = ALU_AND;
          `FN_OR:  aluOp = ALU_OR;
          `FN_SLT: aluOp = ALU_SLT;
          default: aluOp = ALU_NONE;
        endcase
      end
      default:    aluOp = ALU_NONE;
    endcase
  end

  // ==================== datapath
  always_comb begin
    case (aluOp)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // signed compare, 1 or 0
      ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      // unknown funct and jr end up here
      default: result = '0;
    endcase
  end

  // beq uses this after the subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- regFile.sv
// ====================
// 32 x 32-bit register file, async clear, r0 reads as zero
// ====================
`include "mipsDefines.svh"
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input wire logic clk,
  input wire logic rst,
  regFileIf.regFile rf
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREG];

  // ==================== write port
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // clear the whole array while rst is low
      for (int i = 0; i < `MIPS_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && (rf.waddr != '0)) begin
      // writes to r0 dropped
      regs[rf.waddr] <= rf.wdata;
    end
  end

  // ==================== read ports
  // combinational, r0 forced to zero
  always_comb begin
    if (rf.raddr1 == '0) begin
      rf.rdata1 = '0;
    end else begin
      rf.rdata1 = regs[rf.raddr1];
    end
  end

  always_comb begin
    if (rf.raddr2 == '0) begin
      rf.rdata2 = '0;
    end else begin
      rf.rdata2 = regs[rf.raddr2];
    end
  end

endmodule

`default_nettype wire

//--- pcUnit.sv
// ====================
// program counter and next-address select
// ====================
`include "mipsDefines.svh"
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    jump,
  input  wire logic                    branchTaken,
  input  wire logic                    jumpReg,
  input  wire logic [`MIPS_XLEN-1:0]   branchOffset,
  input  wire logic [25:0]             jumpIndex,
  input  wire logic [`MIPS_XLEN-1:0]   regTarget,
  output logic [`MIPS_XLEN-1:0]        pc,
  output logic [`MIPS_XLEN-1:0]        pcPlus4
);

  logic [`MIPS_XLEN-1:0] pcReg;
  logic [`MIPS_XLEN-1:0] pcNext;
  logic [`MIPS_XLEN-1:0] branchTarget;
  logic [`MIPS_XLEN-1:0] jumpTarget;

  assign pcPlus4 = pcReg + `MIPS_XLEN'd4;
  // word offset to byte offset
  assign branchTarget = pcPlus4 + {branchOffset[`MIPS_XLEN-3:0], 2'b00};
  // region bits of pc+4 with the 26-bit index
  assign jumpTarget = {pcPlus4[`MIPS_XLEN-1:`MIPS_XLEN-4], jumpIndex, 2'b00};

  // priority jump, taken branch, jr, then sequential
  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else if (jumpReg) begin
      pcNext = regTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pc = pcReg;

endmodule

`default_nettype wire

//--- mipsCore.sv
// ====================
// single-cycle MIPS subset core, top level
// imem and dmem live outside and answer combinationally
// ====================
`include "mipsDefines.svh"
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
  input  wire logic                      clk,
  input  wire logic                      rst,
  // fetch
  input  wire logic [`MIPS_XLEN-1:0]     inst,
  output logic [`MIPS_XLEN-1:0]          instAddr,
  // data memory
  input  wire logic [`MIPS_XLEN-1:0]     memRdata,
  output logic [`MIPS_DADDR_W-1:0]       memAddr,
  output logic [`MIPS_XLEN-1:0]          memWdata,
  output logic                           memCen,
  output logic                           memWen,
  // write-back observe
  output logic [`MIPS_XLEN-1:0]          rfWriteData
);
  import mipsPkg::*;

  // ==================== instruction fields
  logic [5:0]            opcode;
  logic [4:0]            rs;
  logic [4:0]            rt;
  logic [4:0]            rd;
  logic [5:0]            funct;
  logic [15:0]           imm16;
  logic [25:0]           jumpIndex;
  logic [`MIPS_XLEN-1:0] immExt;

  assign opcode    = inst[31:26];
  assign rs        = inst[25:21];
  assign rt        = inst[20:16];
  assign rd        = inst[15:11];
  assign funct     = inst[5:0];
  assign imm16     = inst[15:0];
  assign jumpIndex = inst[25:0];
  // sign extension of the 16-bit immediate
  assign immExt = {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

  ctrlT                  ctrl;
  logic [`MIPS_XLEN-1:0] aluB;
  logic [`MIPS_XLEN-1:0] aluResult;
  logic                  aluZero;
  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] pcPlus4;

  regFileIf rfBus ();

  // ==================== control
  mainDecode u_mainDecode (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  // ==================== register file
  assign rfBus.raddr1 = rs;
  assign rfBus.raddr2 = rt;
  // destination rt, rd, or r31 for jal
  assign rfBus.waddr = ctrl.link ? 5'd31 : (ctrl.regDst ? rd : rt);
  assign rfBus.we    = ctrl.regWrite;
  // write-back from ALU, memory, or pc+4 for jal
  assign rfBus.wdata = ctrl.link ? pcPlus4 : (ctrl.memToReg ? memRdata : aluResult);

  regFile u_regFile (
    .clk (clk),
    .rst (rst),
    .rf  (rfBus.regFile)
  );

  // ==================== execute
  // immediate for lw/sw offsets
  assign aluB = ctrl.aluSrc ? immExt : rfBus.rdata2;

  aluUnit u_aluUnit (
    .aluClass (ctrl.aluClass),
    .funct    (funct),
    .a        (rfBus.rdata1),
    .b        (aluB),
    .result   (aluResult),
    .zero     (aluZero)
  );

  // ==================== next pc
  pcUnit u_pcUnit (
    .clk          (clk),
    .rst          (rst),
    .jump         (ctrl.jump),
    .branchTaken  (ctrl.branch & aluZero),
    .jumpReg      (ctrl.jumpReg),
    .branchOffset (immExt),
    .jumpIndex    (jumpIndex),
    .regTarget    (rfBus.rdata1),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  // ==================== outputs
  assign instAddr    = pc;
  assign rfWriteData = rfBus.wdata;
  // word address from the byte address
  assign memAddr  = aluResult[`MIPS_DADDR_W+1:2];
  assign memWdata = rfBus.rdata2;
  // active low, chip enable only for lw and sw
  assign memCen = ~(ctrl.memToReg | ctrl.memWrite);
  assign memWen = ~ctrl.memWrite;

endmodule

`default_nettype wire

//--- tbMipsCore.sv
// ====================
// directed testbench for mipsCore with imem/dmem models and an ISA model
// ====================
`include "mipsDefines.svh"
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore;
  logic                     clk;
  logic                     rst;
  logic                     running;
  logic [`MIPS_XLEN-1:0]    inst;
  logic [`MIPS_XLEN-1:0]    instAddr;
  logic [`MIPS_XLEN-1:0]    memRdata;
  logic [`MIPS_DADDR_W-1:0] memAddr;
  logic [`MIPS_XLEN-1:0]    memWdata;
  logic                     memCen;
  logic                     memWen;
  logic [`MIPS_XLEN-1:0]    rfWriteData;

  // ==================== memories and model state
  logic [31:0] rom [64];
  logic [31:0] dmem [128];
  logic [31:0] dmemInit [128];
  // ISA model registers, memory copy and pc
  logic [31:0] mr [32];
  logic [31:0] refMem [128];
  logic [31:0] mpc;
  logic [31:0] lfsr;

  mipsCore u_mipsCore (
    .clk         (clk),
    .rst         (rst),
    .inst        (inst),
    .instAddr    (instAddr),
    .memRdata    (memRdata),
    .memAddr     (memAddr),
    .memWdata    (memWdata),
    .memCen      (memCen),
    .memWen      (memWen),
    .rfWriteData (rfWriteData)
  );

  always #10 clk = ~clk;

  // zero word on inst while the core is held
  assign inst     = running ? rom[instAddr[7:2]] : '0;
  assign memRdata = (!memCen && memWen) ? dmem[memAddr] : '0;

  // dmem reloads from its init image while held and writes on sw
  always @(posedge clk) begin
    if (!running) begin
      for (int i = 0; i < 128; i++) begin
        dmem[i[6:0]] <= dmemInit[i[6:0]];
      end
    end else if (!memCen && !memWen) begin
      dmem[memAddr] <= memWdata;
    end
  end

  // ==================== helpers
  task automatic failRun(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      failRun("run stopped at the first mismatch");
    end
  endtask

  // galois lfsr stepped once per bit
  function automatic logic [31:0] randWord();
    logic [31:0] w;
    logic        b;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 32'h8020_0003;
      end
      w = {w[30:0], b};
    end
    return w;
  endfunction

  // instruction encoders
  function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [5:0] fn);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  task automatic clearMemories();
    for (int i = 0; i < 128; i++) begin
      if (i < 64) begin
        rom[i[5:0]] = '0;
      end
      // fill tied to the full word address
      dmemInit[i[6:0]] = 32'hd0d0_0000 + 32'(i) * 32'h0000_0101;
    end
  endtask

  // ==================== reference model for one instruction
  task automatic stepModel();
    logic [31:0] minst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] wb;
    logic [31:0] pc4;
    logic [31:0] nextPc;
    logic [4:0]  wreg;
    logic        doWrite;
    logic        expCen;
    logic        expWen;
    minst   = rom[mpc[7:2]];
    a       = mr[minst[25:21]];
    b       = mr[minst[20:16]];
    imm     = {{16{minst[15]}}, minst[15:0]};
    addr    = a + imm;
    pc4     = mpc + 32'd4;
    nextPc  = pc4;
    wb      = '0;
    wreg    = minst[20:16];
    doWrite = 1'b0;
    expCen  = 1'b1;
    expWen  = 1'b1;
    case (minst[31:26])
      `OP_RTYPE: begin
        wreg    = minst[15:11];
        doWrite = (minst[5:0] != `FN_JR);
        case (minst[5:0])
          `FN_ADD: wb = a + b;
          `FN_SUB: wb = a - b;
          `FN_AND: wb = a & b;
          `FN_OR:  wb = a | b;
          `FN_SLT: wb = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          `FN_JR:  nextPc = a;
          default: wb = '0;
        endcase
      end
      `OP_LW: begin
        doWrite = 1'b1;
        expCen  = 1'b0;
        wb      = refMem[addr[8:2]];
      end
      `OP_SW: begin
        expCen = 1'b0;
        expWen = 1'b0;
        refMem[addr[8:2]] = b;
      end
      `OP_BEQ: begin
        if (a == b) begin
          nextPc = pc4 + {imm[29:0], 2'b00};
        end
      end
      `OP_J: nextPc = {pc4[31:28], minst[25:0], 2'b00};
      `OP_JAL: begin
        // link address into r31
        nextPc  = {pc4[31:28], minst[25:0], 2'b00};
        wreg    = 5'd31;
        wb      = pc4;
        doWrite = 1'b1;
      end
      default: wb = '0;
    endcase
    checkVal("instAddr", mpc, instAddr);
    checkVal("memCen", 32'(expCen), 32'(memCen));
    checkVal("memWen", 32'(expWen), 32'(memWen));
    if (doWrite) begin
      checkVal("rfWriteData", wb, rfWriteData);
    end
    if (!expCen) begin
      checkVal("memAddr", 32'(addr[8:2]), 32'(memAddr));
    end
    if (!expWen) begin
      checkVal("memWdata", b, memWdata);
    end
    if (doWrite && wreg != 5'd0) begin
      mr[wreg] = wb;
    end
    mpc = nextPc;
  endtask

  // ==================== reset and run
  task automatic startProgram();
    @(posedge clk);
    rst     <= 1'b0;
    running <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    // held state with the zero word on inst
    checkVal("instAddr", 32'd0, instAddr);
    checkVal("memCen", 32'd1, 32'(memCen));
    checkVal("memWen", 32'd1, 32'(memWen));
    checkVal("rfWriteData", 32'd0, rfWriteData);
    for (int i = 0; i < 128; i++) begin
      if (i < 32) begin
        mr[i[4:0]] = '0;
      end
      refMem[i[6:0]] = dmemInit[i[6:0]];
    end
    mpc = '0;
    @(posedge clk);
    rst     <= 1'b1;
    running <= 1'b1;
  endtask

  task automatic runProgram(input int count);
    int retired;
    int cycles;
    retired = 0;
    cycles  = 0;
    while (retired < count) begin
      @(negedge clk);
      cycles++;
      if (cycles > count + 16) begin
        failRun("program did not retire its instructions in time");
      end
      stepModel();
      retired++;
    end
    // target of the last instruction
    @(negedge clk);
    checkVal("instAddr", mpc, instAddr);
  endtask

  // ==================== directed tests
  task automatic arithmeticTest();
    clearMemories();
    dmemInit[0] = randWord();
    dmemInit[1] = randWord();
    // negative and positive slt operands
    dmemInit[2] = randWord() | 32'h8000_0000;
    dmemInit[3] = randWord() & 32'h7fff_ffff;
    rom[0]  = encI(`OP_LW, 5'd0, 5'd1, 16'd0);
    rom[1]  = encI(`OP_LW, 5'd0, 5'd2, 16'd4);
    rom[2]  = encI(`OP_LW, 5'd0, 5'd3, 16'd8);
    rom[3]  = encI(`OP_LW, 5'd0, 5'd4, 16'd12);
    rom[4]  = encR(5'd1, 5'd2, 5'd5, `FN_ADD);
    rom[5]  = encR(5'd1, 5'd2, 5'd6, `FN_SUB);
    rom[6]  = encR(5'd1, 5'd2, 5'd7, `FN_AND);
    rom[7]  = encR(5'd1, 5'd2, 5'd8, `FN_OR);
    rom[8]  = encR(5'd3, 5'd4, 5'd9, `FN_SLT);
    rom[9]  = encR(5'd4, 5'd3, 5'd10, `FN_SLT);
    // write aimed at r0 then r0 read back through add
    rom[10] = encR(5'd1, 5'd2, 5'd0, `FN_ADD);
    rom[11] = encR(5'd0, 5'd1, 5'd11, `FN_ADD);
    startProgram();
    runProgram(12);
  endtask

  task automatic memoryTest();
    clearMemories();
    dmemInit[4] = randWord();
    dmemInit[5] = randWord();
    dmemInit[6] = 32'd200;
    rom[0] = encI(`OP_LW, 5'd0, 5'd1, 16'd16);
    rom[1] = encI(`OP_LW, 5'd0, 5'd2, 16'd20);
    rom[2] = encI(`OP_LW, 5'd0, 5'd3, 16'd24);
    rom[3] = encI(`OP_SW, 5'd0, 5'd1, 16'd100);
    rom[4] = encI(`OP_SW, 5'd3, 5'd2, -16'sd8);
    rom[5] = encR(5'd1, 5'd2, 5'd4, `FN_ADD);
    // read back both stores
    rom[6] = encI(`OP_LW, 5'd0, 5'd5, 16'd100);
    rom[7] = encI(`OP_LW, 5'd3, 5'd6, -16'sd8);
    startProgram();
    runProgram(8);
  endtask

  task automatic branchTest();
    clearMemories();
    dmemInit[0] = randWord();
    dmemInit[1] = dmemInit[0];
    dmemInit[2] = dmemInit[0] ^ 32'h0000_0100;
    rom[0]  = encI(`OP_LW, 5'd0, 5'd1, 16'd0);
    rom[1]  = encI(`OP_LW, 5'd0, 5'd2, 16'd4);
    rom[2]  = encI(`OP_LW, 5'd0, 5'd3, 16'd8);
    rom[3]  = encI(`OP_BEQ, 5'd1, 5'd3, 16'd5);
    rom[4]  = encI(`OP_BEQ, 5'd1, 5'd2, 16'd3);
    rom[5]  = encR(5'd1, 5'd3, 5'd4, `FN_ADD);
    rom[6]  = encI(`OP_BEQ, 5'd0, 5'd0, 16'd3);
    rom[7]  = encR(5'd1, 5'd1, 5'd9, `FN_ADD);
    // backward offsets not taken then taken
    rom[8]  = encI(`OP_BEQ, 5'd1, 5'd3, -16'sd4);
    rom[9]  = encI(`OP_BEQ, 5'd1, 5'd2, -16'sd5);
    rom[10] = encR(5'd2, 5'd3, 5'd5, `FN_ADD);
    startProgram();
    runProgram(10);
  endtask

  task automatic jumpTest();
    clearMemories();
    dmemInit[0] = randWord();
    rom[0] = encI(`OP_LW, 5'd0, 5'd1, 16'd0);
    rom[1] = encJ(`OP_J, 26'd4);
    rom[2] = encR(5'd1, 5'd1, 5'd2, `FN_ADD);
    rom[3] = encR(5'd1, 5'd1, 5'd3, `FN_ADD);
    rom[4] = encJ(`OP_JAL, 26'd8);
    rom[5] = encR(5'd1, 5'd1, 5'd4, `FN_ADD);
    rom[8] = encR(5'd1, 5'd1, 5'd5, `FN_ADD);
    // return through r31
    rom[9] = encR(5'd31, 5'd0, 5'd0, `FN_JR);
    startProgram();
    runProgram(6);
  endtask

  // ==================== main sequence
  initial begin
    clk     = 1'b0;
    rst     = 1'b0;
    running = 1'b0;
    lfsr    = 32'd23;
    clearMemories();
    arithmeticTest();
    memoryTest();
    branchTest();
    jumpTest();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
mipsPkg.sv
regFileIf.sv
mainDecode.sv
aluUnit.sv
regFile.sv
pcUnit.sv
mipsCore.sv
tbMipsCore.sv

//--- run.sh
#!/usr/bin/env bash
# build the core and its testbench with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 -f list.f --top-module tbMipsCore -o simMipsCore
./obj_dir/simMipsCore
